/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_ttc
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_ttc.sv */
// testbench for one ttc channel
// directed tests over the bus, readback, prescaler, interval, restart,
// match interrupt and counter disable

module tb_ttc;
  timeunit 1ns;
  timeprecision 1ps;

  // run limit in clock cycles
  localparam int unsigned MAX_CYCLES = 4000;
  // cycles one bus read adds between two count samples
  localparam int READ_SPAN = 3;

  logic                pclk8 = 1'b0;
  logic                n_p_reset8;
  logic                psel;
  logic                penable;
  logic                pwrite;
  ttc_pkg::ttc_addr_t  paddr;
  ttc_pkg::ttc_value_t pwdata;
  ttc_pkg::ttc_value_t prdata;
  logic                irq;
  int unsigned         cycles = 0;

  ttc_timer i_dut (
    .pclk8      (pclk8),
    .n_p_reset8 (n_p_reset8),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .irq        (irq)
  );

  // 10 ns clock
  always #5 pclk8 = ~pclk8;

  // ------------------------------------------------------------------------
  // run limit
  // ------------------------------------------------------------------------
  always @(posedge pclk8)
  begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
      abort_run($sformatf("run stopped after %0d cycles without finishing", MAX_CYCLES));
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic check_value(input string name, input ttc_pkg::ttc_value_t got,
                             input ttc_pkg::ttc_value_t exp);
    if (got !== exp)
      abort_run($sformatf("error at %0d ns: %s = 0x%04h, expected 0x%04h",
                          $time, name, got, exp));
  endtask

  task automatic check_range(input string name, input ttc_pkg::ttc_value_t got,
                             input ttc_pkg::ttc_value_t lo, input ttc_pkg::ttc_value_t hi);
    if (got < lo || got > hi)
      abort_run($sformatf("error at %0d ns: %s = %0d, expected %0d to %0d",
                          $time, name, got, lo, hi));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("error at %0d ns: %s = %b, expected %b", $time, name, got, exp));
  endtask

  // ------------------------------------------------------------------------
  // bus access as one setup and one access cycle
  // ------------------------------------------------------------------------
  task automatic bus_write(input ttc_pkg::ttc_addr_t addr, input ttc_pkg::ttc_value_t data);
    @(posedge pclk8);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk8);
    penable <= 1'b1;
    // write lands on this edge
    @(posedge pclk8);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic bus_read(input ttc_pkg::ttc_addr_t addr, output ttc_pkg::ttc_value_t data);
    @(posedge pclk8);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk8);
    penable <= 1'b1;
    // prdata settled mid access cycle
    @(negedge pclk8);
    data = prdata;
    @(posedge pclk8);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk8);
  endtask

  task automatic wait_for_irq(input int limit);
    int n;
    n = 0;
    @(negedge pclk8);
    while (!irq && n < limit)
    begin
      @(negedge pclk8);
      n++;
    end
    if (!irq)
      abort_run($sformatf("irq did not rise within %0d cycles", limit));
  endtask

  // two count samples span cycles apart
  task automatic count_delta(input int span, output ttc_pkg::ttc_value_t delta);
    ttc_pkg::ttc_value_t first;
    ttc_pkg::ttc_value_t second;
    bus_read(ttc_pkg::ADDR_COUNT, first);
    wait_cycles(span - READ_SPAN);
    bus_read(ttc_pkg::ADDR_COUNT, second);
    delta = second - first;
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic reset_readback();
    ttc_pkg::ttc_value_t rd;
    ttc_pkg::ttc_value_t wr;
    // count value runs from reset and is not read here
    check_bit("irq", irq, 1'b0);
    bus_read(ttc_pkg::ADDR_CLK_CTRL, rd);
    check_value("clk_ctrl", rd, 16'h0000);
    bus_read(ttc_pkg::ADDR_CNTR_CTRL, rd);
    check_value("cntr_ctrl", rd, 16'h0000);
    bus_read(ttc_pkg::ADDR_INTERVAL, rd);
    check_value("interval", rd, 16'h0000);
    bus_read(ttc_pkg::ADDR_MATCH, rd);
    check_value("match", rd, 16'h0000);
    bus_read(ttc_pkg::ADDR_IRQ_STATUS, rd);
    check_value("irq_status", rd, 16'h0000);
    bus_read(ttc_pkg::ADDR_IRQ_EN, rd);
    check_value("irq_en", rd, 16'h0000);
    // unmapped
    bus_read(5'h1C, rd);
    check_value("unmapped 0x1c", rd, 16'h0000);
    // random data where only the defined bits read back
    wr = ttc_pkg::ttc_value_t'($urandom);
    bus_write(ttc_pkg::ADDR_CLK_CTRL, wr);
    bus_read(ttc_pkg::ADDR_CLK_CTRL, rd);
    check_value("clk_ctrl", rd, wr & 16'h007F);
    wr = ttc_pkg::ttc_value_t'($urandom);
    bus_write(ttc_pkg::ADDR_INTERVAL, wr);
    bus_read(ttc_pkg::ADDR_INTERVAL, rd);
    check_value("interval", rd, wr);
    wr = ttc_pkg::ttc_value_t'($urandom);
    bus_write(ttc_pkg::ADDR_MATCH, wr);
    bus_read(ttc_pkg::ADDR_MATCH, rd);
    check_value("match", rd, wr);
    wr = ttc_pkg::ttc_value_t'($urandom);
    bus_write(ttc_pkg::ADDR_IRQ_EN, wr);
    bus_read(ttc_pkg::ADDR_IRQ_EN, rd);
    check_value("irq_en", rd, wr & 16'h0003);
    bus_write(ttc_pkg::ADDR_IRQ_EN, 16'h0000);
    bus_write(ttc_pkg::ADDR_CLK_CTRL, 16'h0000);
  endtask

  task automatic prescaled_count();
    ttc_pkg::ttc_value_t delta;
    ttc_pkg::ttc_value_t exp;
    // ps_en with ps_value 1 for a divide by 4
    bus_write(ttc_pkg::ADDR_CLK_CTRL, 16'h0003);
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0000);
    count_delta(64, delta);
    exp = ttc_pkg::ttc_value_t'(64 >> 2);
    check_range("count delta, prescaled", delta, exp - 16'd1, exp + 16'd1);
    // bypass gives one step per cycle
    bus_write(ttc_pkg::ADDR_CLK_CTRL, 16'h0000);
    count_delta(64, delta);
    check_range("count delta, bypassed", delta, 16'd63, 16'd65);
  endtask

  task automatic interval_up();
    ttc_pkg::ttc_value_t rd;
    ttc_pkg::ttc_event_t ovf_only;
    ovf_only              = '0;
    ovf_only.interval_ovf = 1'b1;
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0001);
    bus_write(ttc_pkg::ADDR_INTERVAL, 16'd9);
    bus_write(ttc_pkg::ADDR_IRQ_EN, 16'h0001);
    // start with clean status
    bus_read(ttc_pkg::ADDR_IRQ_STATUS, rd);
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0002);
    wait_for_irq(40);
    repeat (3)
    begin
      bus_read(ttc_pkg::ADDR_COUNT, rd);
      check_range("count in interval", rd, 16'd0, 16'd9);
    end
    // stop counting so no new event races the clear
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0003);
    @(negedge pclk8);
    check_bit("irq before status read", irq, 1'b1);
    bus_read(ttc_pkg::ADDR_IRQ_STATUS, rd);
    check_value("irq_status", rd, {14'd0, ovf_only});
    @(negedge pclk8);
    check_bit("irq after status read", irq, 1'b0);
  endtask

  task automatic down_restart();
    ttc_pkg::ttc_value_t first;
    ttc_pkg::ttc_value_t later;
    bus_write(ttc_pkg::ADDR_IRQ_EN, 16'h0000);
    bus_write(ttc_pkg::ADDR_INTERVAL, 16'd200);
    // restart, decrement, interval mode
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0016);
    bus_read(ttc_pkg::ADDR_COUNT, first);
    check_range("count after restart", first, 16'd180, 16'd200);
    wait_cycles(20);
    bus_read(ttc_pkg::ADDR_COUNT, later);
    check_range("count later", later, 16'd0, first - 16'd1);
  endtask

  task automatic match_irq();
    ttc_pkg::ttc_value_t rd;
    ttc_pkg::ttc_event_t status;
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0001);
    bus_write(ttc_pkg::ADDR_MATCH, 16'd5);
    bus_write(ttc_pkg::ADDR_INTERVAL, 16'd9);
    bus_write(ttc_pkg::ADDR_IRQ_EN, 16'h0002);
    bus_read(ttc_pkg::ADDR_IRQ_STATUS, rd);
    // match_en with interval mode up
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h000A);
    wait_for_irq(40);
    bus_read(ttc_pkg::ADDR_IRQ_STATUS, rd);
    status = ttc_pkg::ttc_event_t'(rd[1:0]);
    check_bit("irq_status.match", status.match, 1'b1);
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0002);
    bus_read(ttc_pkg::ADDR_IRQ_STATUS, rd);
    wait_cycles(20);
    @(negedge pclk8);
    check_bit("irq with match off", irq, 1'b0);
  endtask

  task automatic count_disable();
    ttc_pkg::ttc_value_t delta;
    bus_write(ttc_pkg::ADDR_CNTR_CTRL, 16'h0003);
    count_delta(50, delta);
    check_value("count delta while disabled", delta, 16'h0000);
  endtask

  // ------------------------------------------------------------------------
  // sequence
  // ------------------------------------------------------------------------
  initial
  begin
    n_p_reset8 <= 1'b0;
    psel       <= 1'b0;
    penable    <= 1'b0;
    pwrite     <= 1'b0;
    paddr      <= '0;
    pwdata     <= '0;
    void'($urandom(16010));
    repeat (5) @(posedge pclk8);
    n_p_reset8 <= 1'b1;
    @(negedge pclk8);
    reset_readback();
    prescaled_count();
    interval_up();
    down_restart();
    match_irq();
    count_disable();
    $display("Regression passed");
    $finish;
  end

endmodule

/* hdl/ttc_apb_fsm.sv */
// ttc bus access, follows the setup and access phases of a zero-wait
// APB transfer and turns the access cycle into register strobes

module ttc_apb_fsm (
  input  logic              pclk8,
  input  logic              n_p_reset8,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  ttc_pkg::ttc_addr_t paddr,
  output ttc_pkg::reg_sel_t  reg_sel
);

  // phase of the previous cycle
  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } apb_state_t;

  apb_state_t state_q;
  apb_state_t state_d;
  logic       access_now;

  // access only counts when it follows a setup cycle
  assign access_now = (state_q == setup) && psel && penable;

  always_comb
  begin
    if (psel && !penable)
      state_d = setup;
    else if (access_now)
      state_d = access;
    else
      state_d = idle;
  end

  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      state_q <= idle;
    else
      state_q <= state_d;
  end

  // ------------------------------------------------------------------------
  // address decode, one strobe per access
  // ------------------------------------------------------------------------
  always_comb
  begin
    reg_sel              = '0;
    reg_sel.wr_clk_ctrl  = access_now && pwrite && (paddr == ttc_pkg::ADDR_CLK_CTRL);
    reg_sel.wr_cntr_ctrl = access_now && pwrite && (paddr == ttc_pkg::ADDR_CNTR_CTRL);
    reg_sel.wr_interval  = access_now && pwrite && (paddr == ttc_pkg::ADDR_INTERVAL);
    reg_sel.wr_match     = access_now && pwrite && (paddr == ttc_pkg::ADDR_MATCH);
    reg_sel.wr_irq_en    = access_now && pwrite && (paddr == ttc_pkg::ADDR_IRQ_EN);
    // status read clears sticky bits
    reg_sel.rd_status    = access_now && !pwrite && (paddr == ttc_pkg::ADDR_IRQ_STATUS);
  end

  // penable only rises right after a setup cycle
  a_setup_first: assert property (@(posedge pclk8) disable iff (!n_p_reset8)
    $rose(penable) |-> $past(psel && !penable));

  a_one_strobe: assert property (@(posedge pclk8) disable iff (!n_p_reset8)
    $onehot0(reg_sel));

endmodule

/* hdl/ttc_count_rst.sv */
// ttc count reset, holds the clock control register and drops the
// counter enable for one cycle when the restart bit rises

module ttc_count_rst (
  input  logic                pclk8,
  input  logic                n_p_reset8,
  input  ttc_pkg::ttc_value_t pwdata,
  input  logic                wr_clk_ctrl,
  input  logic                restart,
  output logic                count_en,
  output ttc_pkg::clk_ctrl_t  clk_ctrl
);

  // restart already acted on
  logic restart_seen;

  // ------------------------------------------------------------------------
  // restart edge and counter enable
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
    begin
      restart_seen <= 1'b0;
      count_en     <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      // first cycle with restart high
      restart_seen <= 1'b1;
      count_en     <= 1'b0;
    end
    else
    begin
      // rearm once software clears restart
      if (!restart)
        restart_seen <= 1'b0;
      count_en <= 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // clock control register
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      clk_ctrl <= '0;
    else if (wr_clk_ctrl)
      // low 7 data bits only
      clk_ctrl <= pwdata[6:0];
  end

  // enable drop is a single cycle
  a_single_drop: assert property (@(posedge pclk8) disable iff (!n_p_reset8)
    !count_en |=> count_en);

endmodule

/* hdl/ttc_counter.sv */
// ttc counter, 16 bit up or down count, free running or interval mode
// with interval/overflow and match event pulses

module ttc_counter (
  input  logic                pclk8,
  input  logic                n_p_reset8,
  input  logic                count_en,
  input  logic                tick,
  input  ttc_pkg::cntr_ctrl_t cntr_ctrl,
  input  ttc_pkg::ttc_value_t interval,
  input  ttc_pkg::ttc_value_t match,
  output ttc_pkg::ttc_value_t count_value,
  output ttc_pkg::ttc_event_t events
);

  ttc_pkg::ttc_value_t start_value;
  ttc_pkg::ttc_value_t next_value;
  logic                wrap;
  logic                step;

  // value loaded while count_en is low
  always_comb
  begin
    if (!cntr_ctrl.decrement)
      start_value = '0;
    else if (cntr_ctrl.interval_mode)
      start_value = interval;
    else
      start_value = 16'hFFFF;
  end

  assign step = tick && !cntr_ctrl.count_dis;

  // ------------------------------------------------------------------------
  // next count and wrap detect
  // ------------------------------------------------------------------------
  always_comb
  begin
    wrap       = 1'b0;
    next_value = count_value;
    if (cntr_ctrl.decrement)
    begin
      if (count_value == 16'h0000)
      begin
        wrap       = 1'b1;
        // reload interval, else roll under
        next_value = cntr_ctrl.interval_mode ? interval : 16'hFFFF;
      end
      else
        next_value = count_value - 16'd1;
    end
    else if (cntr_ctrl.interval_mode)
    begin
      // count past interval also returns to 0
      if (count_value >= interval)
      begin
        wrap       = 1'b1;
        next_value = '0;
      end
      else
        next_value = count_value + 16'd1;
    end
    else
    begin
      wrap       = (count_value == 16'hFFFF);
      next_value = count_value + 16'd1;
    end
  end

  // ------------------------------------------------------------------------
  // count register and event pulses
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
    begin
      count_value <= '0;
      events      <= '0;
    end
    else
    begin
      // pulses last one cycle
      events <= '0;
      if (!count_en)
        count_value <= start_value;
      else if (step)
      begin
        count_value         <= next_value;
        events.interval_ovf <= wrap;
        events.match        <= cntr_ctrl.match_en && (next_value == match);
      end
    end
  end

  // no event after a cycle with the enable dropped
  a_no_event: assert property (@(posedge pclk8) disable iff (!n_p_reset8)
    !count_en |=> (events == '0));

endmodule

/* hdl/ttc_pkg.sv */
// triple timer counter, shared definitions for one channel
// register map widths, control field layouts, strobes and event pulses

package ttc_pkg;

  // ------------------------------------------------------------------------
  // plain widths
  // ------------------------------------------------------------------------
  // counter, interval, match and bus data
  typedef logic [15:0] ttc_value_t;
  // byte address into the register map
  typedef logic [4:0]  ttc_addr_t;

  // register map
  parameter ttc_addr_t ADDR_CLK_CTRL   = 5'h00;
  parameter ttc_addr_t ADDR_CNTR_CTRL  = 5'h04;
  // read only
  parameter ttc_addr_t ADDR_COUNT      = 5'h08;
  parameter ttc_addr_t ADDR_INTERVAL   = 5'h0C;
  parameter ttc_addr_t ADDR_MATCH      = 5'h10;
  parameter ttc_addr_t ADDR_IRQ_STATUS = 5'h14;
  parameter ttc_addr_t ADDR_IRQ_EN     = 5'h18;

  // ------------------------------------------------------------------------
  // register layouts
  // ------------------------------------------------------------------------
  // clock control, edge and source select kept for readback only
  typedef struct packed {
    logic       edge_sel;
    logic       ext_sel;
    // divide by 2**(ps_value+1)
    logic [3:0] ps_value;
    logic       ps_en;
  } clk_ctrl_t;

  // counter control
  typedef struct packed {
    logic restart;
    logic match_en;
    logic decrement;
    logic interval_mode;
    logic count_dis;
  } cntr_ctrl_t;

  // event pulses, same layout as irq status and enable
  typedef struct packed {
    logic match;
    logic interval_ovf;
  } ttc_event_t;

  // one-cycle register strobes from the bus side
  typedef struct packed {
    logic wr_clk_ctrl;
    logic wr_cntr_ctrl;
    logic wr_interval;
    logic wr_match;
    logic wr_irq_en;
    logic rd_status;
  } reg_sel_t;

endpackage

/* hdl/ttc_prescaler.sv */
// ttc prescaler, divides the bus clock by 2**(ps_value+1) into the
// counter tick, or passes the enable through when bypassed

module ttc_prescaler (
  input  logic               pclk8,
  input  logic               n_p_reset8,
  input  logic               count_en,
  input  ttc_pkg::clk_ctrl_t clk_ctrl,
  output logic               tick
);

  ttc_pkg::ttc_value_t ps_timer;
  // last timer value of a prescale period
  ttc_pkg::ttc_value_t ps_term;
  logic                ps_wrap;

  // 2**16 wraps to 0 so ps_value 15 ends at 0xffff
  assign ps_term = ttc_pkg::ttc_value_t'((16'd2 << clk_ctrl.ps_value) - 16'd1);
  assign ps_wrap = (ps_timer == ps_term);

  // ------------------------------------------------------------------------
  // prescale timer
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      ps_timer <= '0;
    else if (!count_en || !clk_ctrl.ps_en)
      // held clear while stopped or bypassed
      ps_timer <= '0;
    else if (ps_wrap)
      ps_timer <= '0;
    else
      ps_timer <= ps_timer + 16'd1;
  end

  // bypass gives a tick every enabled cycle
  always_comb
  begin
    if (!clk_ctrl.ps_en)
      tick = count_en;
    else
      tick = count_en && ps_wrap;
  end

endmodule

/* hdl/ttc_regs.sv */
// ttc register block, counter control, interval, match, interrupt
// status and enable, read data mux and the interrupt line

module ttc_regs (
  input  logic                pclk8,
  input  logic                n_p_reset8,
  input  ttc_pkg::reg_sel_t   reg_sel,
  input  ttc_pkg::ttc_addr_t  paddr,
  input  ttc_pkg::ttc_value_t pwdata,
  input  ttc_pkg::ttc_value_t count_value,
  input  ttc_pkg::clk_ctrl_t  clk_ctrl,
  input  ttc_pkg::ttc_event_t events,
  output ttc_pkg::cntr_ctrl_t cntr_ctrl,
  output ttc_pkg::ttc_value_t interval,
  output ttc_pkg::ttc_value_t match,
  output ttc_pkg::ttc_value_t prdata,
  output logic                irq
);

  ttc_pkg::ttc_event_t irq_status;
  ttc_pkg::ttc_event_t irq_en;

  // ------------------------------------------------------------------------
  // writable registers
  // ------------------------------------------------------------------------
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
    begin
      cntr_ctrl <= '0;
      interval  <= '0;
      match     <= '0;
      irq_en    <= '0;
    end
    else
    begin
      if (reg_sel.wr_cntr_ctrl)
        cntr_ctrl <= pwdata[4:0];
      if (reg_sel.wr_interval)
        interval <= pwdata;
      if (reg_sel.wr_match)
        match <= pwdata;
      if (reg_sel.wr_irq_en)
        irq_en <= pwdata[1:0];
    end
  end

  // sticky status, clear on read, a new event wins over the clear
  always_ff @(posedge pclk8 or negedge n_p_reset8)
  begin
    if (!n_p_reset8)
      irq_status <= '0;
    else if (reg_sel.rd_status)
      irq_status <= events;
    else
      irq_status <= irq_status | events;
  end

  assign irq = |(irq_status & irq_en);

  // ------------------------------------------------------------------------
  // read mux, unmapped reads as 0
  // ------------------------------------------------------------------------
  always_comb
  begin
    case (paddr)
      ttc_pkg::ADDR_CLK_CTRL:   prdata = {9'd0, clk_ctrl};
      ttc_pkg::ADDR_CNTR_CTRL:  prdata = {11'd0, cntr_ctrl};
      ttc_pkg::ADDR_COUNT:      prdata = count_value;
      ttc_pkg::ADDR_INTERVAL:   prdata = interval;
      ttc_pkg::ADDR_MATCH:      prdata = match;
      ttc_pkg::ADDR_IRQ_STATUS: prdata = {14'd0, irq_status};
      ttc_pkg::ADDR_IRQ_EN:     prdata = {14'd0, irq_en};
      default:                  prdata = '0;
    endcase
  end

endmodule

/* hdl/ttc_timer.sv */
// ttc channel top, bus access, count reset, prescaler, counter
// and register block of one timer counter channel

module ttc_timer (
  input  logic                pclk8,
  input  logic                n_p_reset8,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  ttc_pkg::ttc_addr_t  paddr,
  input  ttc_pkg::ttc_value_t pwdata,
  output ttc_pkg::ttc_value_t prdata,
  output logic                irq
);

  ttc_pkg::reg_sel_t   reg_sel;
  ttc_pkg::clk_ctrl_t  clk_ctrl;
  ttc_pkg::cntr_ctrl_t cntr_ctrl;
  ttc_pkg::ttc_value_t interval;
  ttc_pkg::ttc_value_t match;
  ttc_pkg::ttc_value_t count_value;
  ttc_pkg::ttc_event_t events;
  logic                count_en;
  logic                tick;

  // bus phases to strobes
  ttc_apb_fsm i_apb_fsm (
    .pclk8      (pclk8),
    .n_p_reset8 (n_p_reset8),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .reg_sel    (reg_sel)
  );

  ttc_count_rst i_count_rst (
    .pclk8       (pclk8),
    .n_p_reset8  (n_p_reset8),
    .pwdata      (pwdata),
    .wr_clk_ctrl (reg_sel.wr_clk_ctrl),
    .restart     (cntr_ctrl.restart),
    .count_en    (count_en),
    .clk_ctrl    (clk_ctrl)
  );

  ttc_prescaler i_prescaler (
    .pclk8      (pclk8),
    .n_p_reset8 (n_p_reset8),
    .count_en   (count_en),
    .clk_ctrl   (clk_ctrl),
    .tick       (tick)
  );

  ttc_counter i_counter (
    .pclk8       (pclk8),
    .n_p_reset8  (n_p_reset8),
    .count_en    (count_en),
    .tick        (tick),
    .cntr_ctrl   (cntr_ctrl),
    .interval    (interval),
    .match       (match),
    .count_value (count_value),
    .events      (events)
  );

  // registers, read data and irq
  ttc_regs i_regs (
    .pclk8       (pclk8),
    .n_p_reset8  (n_p_reset8),
    .reg_sel     (reg_sel),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .count_value (count_value),
    .clk_ctrl    (clk_ctrl),
    .events      (events),
    .cntr_ctrl   (cntr_ctrl),
    .interval    (interval),
    .match       (match),
    .prdata      (prdata),
    .irq         (irq)
  );

endmodule

/* list.f */
hdl/ttc_pkg.sv
hdl/ttc_apb_fsm.sv
hdl/ttc_count_rst.sv
hdl/ttc_prescaler.sv
hdl/ttc_counter.sv
hdl/ttc_regs.sv
hdl/ttc_timer.sv
bench/tb_ttc.sv
